// File: include/rv_pipe_config.svh
`ifndef RV_PIPE_CONFIG_SVH
`define RV_PIPE_CONFIG_SVH

// data and address width
`define RV_XLEN 32

// width of the running commit order number
`define RV_ORDER_W 64

// one byte lane per byte of a word
`define RV_LANES 4

// pc held by an empty packet register
`define RV_RESET_PC 32'h40000000

`endif

// File: rtl/rv_pipe_pkg.sv
`include "rv_pipe_config.svh"

package rv_pipe_pkg;

    typedef logic [`RV_XLEN-1:0]    word_t;     // data or address word
    typedef logic [`RV_ORDER_W-1:0] order_t;    // commit order number
    typedef logic [`RV_LANES-1:0]   mask_t;     // one bit per byte lane
    typedef logic [4:0]             reg_idx_t;  // architectural register index

    // rv32i load funct3 encodings
    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3_e;

    // rv32i store funct3 encodings
    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3_e;

    // source of the memory address
    typedef enum logic {
        pc_out  = 1'b0,
        alu_out = 1'b1
    } addr_sel_e;

    // exe_mem_reg request FSM
    typedef enum logic [1:0] {
        idle      = 2'b00,  // stage empty
        request   = 2'b01,  // request offered to data memory
        wait_resp = 2'b10,  // request taken, response pending
        done      = 2'b11   // record offered downstream
    } mem_state_e;

    typedef struct packed {
        logic          mem_read;
        logic          mem_write;
        load_funct3_e  load_funct3;
        store_funct3_e store_funct3;
        addr_sel_e     addr_sel;
    } mem_ctrl_t;

    typedef struct packed {
        word_t     instr;
        word_t     pc;
        reg_idx_t  rd;
        mem_ctrl_t mem_ctrl;
        word_t     alu_out;     // computed address or result
        word_t     store_data;  // rs2 value, unshifted
    } issue_pkt_t;

    typedef struct packed {
        issue_pkt_t op;
        order_t     order;
    } staged_pkt_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        mask_t byte_en;
        logic  read;
        logic  write;
    } dmem_req_t;

    // retirement record, one per operation
    typedef struct packed {
        order_t   order;
        word_t    instr;
        word_t    pc;
        reg_idx_t rd;
        word_t    mem_addr;
        mask_t    rmask;
        mask_t    wmask;
        word_t    mem_rdata;
        word_t    mem_wdata;
    } commit_pkt_t;

endpackage

// File: rtl/issue_reg.sv
`timescale 1ns/1ps
`include "rv_pipe_config.svh"

module issue_reg
    import rv_pipe_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  issue_pkt_t  op_i,
    input  logic        op_valid_i,
    output logic        op_ready_o,

    output staged_pkt_t stage_o,
    output logic        stage_valid_o,
    input  logic        stage_ready_i
);

    staged_pkt_t stage_q;
    logic        valid_q;
    order_t      order_q;  // number given to the next accepted op
    logic        accept;

    assign op_ready_o = !valid_q || stage_ready_i;  // empty, or leaving this cycle
    assign accept     = op_valid_i && op_ready_o;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
            order_q <= '0;
        end else if (accept) begin
            valid_q <= 1'b1;
            order_q <= order_q + 1'b1;
        end else if (stage_ready_i) begin
            valid_q <= 1'b0;  // item moved on, nothing new
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stage_q       <= '0;
            stage_q.op.pc <= `RV_RESET_PC;
        end else if (accept) begin
            stage_q.op    <= op_i;
            stage_q.order <= order_q;  // stamp in issue order
        end
    end

    assign stage_o       = stage_q;
    assign stage_valid_o = valid_q;

endmodule

// File: rtl/byte_lane_gen.sv
`timescale 1ns/1ps

module byte_lane_gen
    import rv_pipe_pkg::*;
(
    input  mem_ctrl_t mem_ctrl_i,
    input  word_t     addr_i,
    output word_t     mem_addr_o,
    output mask_t     rmask_o,
    output mask_t     wmask_o
);

    logic [1:0] offset;   // byte position within the word
    word_t      aligned;  // address rounded down to a word

    assign offset  = addr_i[1:0];
    assign aligned = {addr_i[$bits(word_t)-1:2], 2'b00};

    always_comb begin
        rmask_o    = '0;
        wmask_o    = '0;
        mem_addr_o = addr_i;  // pass through for non-memory ops

        if (mem_ctrl_i.mem_read) begin
            case (mem_ctrl_i.load_funct3)
                lw: begin
                    rmask_o = '1;
                end
                lh, lhu: begin
                    rmask_o    = mask_t'(2'b11) << offset;  // upper half drops at offset 3
                    mem_addr_o = aligned;
                end
                lb, lbu: begin
                    rmask_o    = mask_t'(1'b1) << offset;
                    mem_addr_o = aligned;
                end
                default: begin
                    rmask_o = '0;  // undefined width, no lanes
                end
            endcase
        end else if (mem_ctrl_i.mem_write) begin
            case (mem_ctrl_i.store_funct3)
                sw: begin
                    wmask_o = '1;
                end
                sh: begin
                    wmask_o    = mask_t'(2'b11) << offset;
                    mem_addr_o = aligned;
                end
                sb: begin
                    wmask_o    = mask_t'(1'b1) << offset;
                    mem_addr_o = aligned;
                end
                default: begin
                    wmask_o = '0;
                end
            endcase
        end
    end

endmodule

// File: rtl/exe_mem_reg.sv
`timescale 1ns/1ps
`include "rv_pipe_config.svh"

module exe_mem_reg
    import rv_pipe_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  staged_pkt_t stage_i,
    input  logic        stage_valid_i,
    output logic        stage_ready_o,

    output dmem_req_t   dmem_req_o,
    output logic        dmem_req_valid_o,
    input  logic        dmem_req_ready_i,
    input  logic        dmem_resp_valid_i,
    input  word_t       dmem_rdata_i,

    output commit_pkt_t commit_o,
    output logic        commit_valid_o,
    input  logic        commit_ready_i
);

    mem_state_e  state_q;
    commit_pkt_t rec_q;
    dmem_req_t   req_q;
    word_t       addr_src;
    word_t       mem_addr;
    mask_t       rmask;
    mask_t       wmask;
    logic        is_mem;
    logic        load_en;

    always_comb begin
        case (stage_i.op.mem_ctrl.addr_sel)
            pc_out:  addr_src = stage_i.op.pc;
            alu_out: addr_src = stage_i.op.alu_out;
        endcase
    end

    byte_lane_gen u_lanes (
        .mem_ctrl_i (stage_i.op.mem_ctrl),
        .addr_i     (addr_src),
        .mem_addr_o (mem_addr),
        .rmask_o    (rmask),
        .wmask_o    (wmask)
    );

    assign is_mem        = stage_i.op.mem_ctrl.mem_read || stage_i.op.mem_ctrl.mem_write;
    assign stage_ready_o = (state_q == idle) || (state_q == done && commit_ready_i);
    assign load_en       = stage_valid_i && stage_ready_o;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= idle;
        end else begin
            case (state_q)
                idle: if (load_en) state_q <= is_mem ? request : done;
                request: if (dmem_req_ready_i) state_q <= wait_resp;  // one request only
                wait_resp: if (dmem_resp_valid_i) state_q <= done;
                done: begin
                    if (load_en) begin
                        state_q <= is_mem ? request : done;  // back to back
                    end else if (commit_ready_i) begin
                        state_q <= idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rec_q    <= '0;
            rec_q.pc <= `RV_RESET_PC;
            req_q    <= '0;
        end else if (load_en) begin
            rec_q.order     <= stage_i.order;
            rec_q.instr     <= stage_i.op.instr;
            rec_q.pc        <= stage_i.op.pc;
            rec_q.rd        <= stage_i.op.rd;
            rec_q.mem_addr  <= mem_addr;
            rec_q.rmask     <= rmask;
            rec_q.wmask     <= wmask;
            rec_q.mem_rdata <= '0;
            rec_q.mem_wdata <= stage_i.op.store_data;  // unshifted
            req_q.addr      <= mem_addr;
            req_q.wdata     <= stage_i.op.store_data;
            req_q.byte_en   <= rmask | wmask;  // at most one is nonzero
            req_q.read      <= stage_i.op.mem_ctrl.mem_read;
            req_q.write     <= stage_i.op.mem_ctrl.mem_write && !stage_i.op.mem_ctrl.mem_read;
        end else if (state_q == wait_resp && dmem_resp_valid_i) begin
            rec_q.mem_rdata <= dmem_rdata_i;  // raw word, no sign extension
        end
    end

    assign dmem_req_o       = req_q;
    assign dmem_req_valid_o = (state_q == request);
    assign commit_o         = rec_q;
    assign commit_valid_o   = (state_q == done);

endmodule

// File: rtl/mem_wb_reg.sv
`timescale 1ns/1ps
`include "rv_pipe_config.svh"

module mem_wb_reg
    import rv_pipe_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  commit_pkt_t commit_i,
    input  logic        commit_valid_i,
    output logic        commit_ready_o,

    output commit_pkt_t commit_o,
    output logic        commit_valid_o,
    input  logic        commit_ready_i
);

    commit_pkt_t rec_q;
    commit_pkt_t rec_d;    // incoming record after cleanup
    logic        valid_q;
    logic        take;
    logic        is_load;

    // a load is the only access with read lanes
    assign is_load = |commit_i.rmask;

    always_comb begin
        rec_d = commit_i;
        if (!is_load) begin
            rec_d.mem_rdata = '0;  // store and alu results carry no read data
        end
    end

    // retirement stall only blocks once this register is full
    assign commit_ready_o = !valid_q || commit_ready_i;
    assign take           = commit_valid_i && commit_ready_o;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (take) begin
            valid_q <= 1'b1;
        end else if (commit_ready_i) begin
            valid_q <= 1'b0;  // retired
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rec_q    <= '0;
            rec_q.pc <= `RV_RESET_PC;
        end else if (take) begin
            rec_q <= rec_d;
        end
    end

    assign commit_o       = rec_q;
    assign commit_valid_o = valid_q;

endmodule

// File: rtl/rv_pipe_top.sv
`timescale 1ns/1ps

module rv_pipe_top
    import rv_pipe_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  issue_pkt_t  op_i,
    input  logic        op_valid_i,
    output logic        op_ready_o,

    output dmem_req_t   dmem_req_o,
    output logic        dmem_req_valid_o,
    input  logic        dmem_req_ready_i,
    input  logic        dmem_resp_valid_i,
    input  word_t       dmem_rdata_i,

    output commit_pkt_t commit_o,
    output logic        commit_valid_o,
    input  logic        commit_ready_i
);

    staged_pkt_t stage_pkt;
    logic        stage_valid;
    logic        stage_ready;
    commit_pkt_t mem_rec;      // record leaving the memory stage
    logic        mem_rec_valid;
    logic        mem_rec_ready;

    issue_reg u_issue (
        .clk           (clk),
        .rst           (rst),
        .op_i          (op_i),
        .op_valid_i    (op_valid_i),
        .op_ready_o    (op_ready_o),
        .stage_o       (stage_pkt),
        .stage_valid_o (stage_valid),
        .stage_ready_i (stage_ready)
    );

    exe_mem_reg u_exe_mem (
        .clk               (clk),
        .rst               (rst),
        .stage_i           (stage_pkt),
        .stage_valid_i     (stage_valid),
        .stage_ready_o     (stage_ready),
        .dmem_req_o        (dmem_req_o),
        .dmem_req_valid_o  (dmem_req_valid_o),
        .dmem_req_ready_i  (dmem_req_ready_i),
        .dmem_resp_valid_i (dmem_resp_valid_i),
        .dmem_rdata_i      (dmem_rdata_i),
        .commit_o          (mem_rec),
        .commit_valid_o    (mem_rec_valid),
        .commit_ready_i    (mem_rec_ready)
    );

    mem_wb_reg u_mem_wb (
        .clk            (clk),
        .rst            (rst),
        .commit_i       (mem_rec),
        .commit_valid_i (mem_rec_valid),
        .commit_ready_o (mem_rec_ready),
        .commit_o       (commit_o),
        .commit_valid_o (commit_valid_o),
        .commit_ready_i (commit_ready_i)
    );

endmodule

// File: tb/rv_pipe_assert.sv
`timescale 1ns/1ps

module rv_pipe_assert
    import rv_pipe_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input issue_pkt_t  op_i,
    input logic        op_valid_i,
    input logic        op_ready_o,
    input logic        dmem_req_valid_o,
    input logic        dmem_req_ready_i,
    input logic        dmem_resp_valid_i,
    input commit_pkt_t commit_o,
    input logic        commit_valid_o,
    input logic        commit_ready_i
);

    logic outstanding;  // request taken, response not yet seen

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            outstanding <= 1'b0;
        end else if (dmem_req_valid_o && dmem_req_ready_i) begin
            outstanding <= 1'b1;
        end else if (dmem_resp_valid_i) begin
            outstanding <= 1'b0;
        end
    end

    a_op_stable: assert property (@(posedge clk) disable iff (rst)
        op_valid_i && !op_ready_o |=> op_valid_i && $stable(op_i))
        else $error("op changed while stalled");

    a_commit_stable: assert property (@(posedge clk) disable iff (rst)
        commit_valid_o && !commit_ready_i |=> commit_valid_o && $stable(commit_o))
        else $error("commit record changed while stalled");

    a_req_reset: assert property (@(posedge clk) rst |-> !dmem_req_valid_o)
        else $error("request valid during reset");

    a_one_req: assert property (@(posedge clk) disable iff (rst)
        outstanding |-> !dmem_req_valid_o)
        else $error("second request before response");

endmodule

bind rv_pipe_top rv_pipe_assert u_assert (.*);

// File: tb/tb_top.sv
`timescale 1ns/1ps
`include "rv_pipe_config.svh"

module tb_top
    import rv_pipe_pkg::*;
();

    localparam int WAIT_LIMIT = 200;  // cycles per wait loop

    logic        clk;
    logic        rst;
    issue_pkt_t  op_i;
    logic        op_valid_i;
    logic        op_ready_o;
    dmem_req_t   dmem_req_o;
    logic        dmem_req_valid_o;
    logic        dmem_req_ready_i;
    logic        dmem_resp_valid_i;
    word_t       dmem_rdata_i;
    commit_pkt_t commit_o;
    logic        commit_valid_o;
    logic        commit_ready_i;

    word_t       mem [0:63];      // memory seen by the DUT
    word_t       ref_mem [0:63];  // program-order copy for expected values
    commit_pkt_t exp_q [$];
    dmem_req_t   req_exp_q [$];   // one entry per memory op, in issue order
    logic [31:0] lcg_state = 32'h6afc7fc8;
    order_t      next_order = '0;
    int          errors = 0;
    int          req_count = 0;
    int          mem_ops = 0;
    logic        stall_en = 1'b0;

    rv_pipe_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // lanes touched by an access of the given funct3 width
    function automatic mask_t lane_mask(logic [2:0] f3, logic [1:0] off);
        case (f3[1:0])
            2'b00:   return mask_t'(4'b0001 << off);
            2'b01:   return mask_t'(4'b0011 << off);  // drops top lane at offset 3
            default: return 4'b1111;
        endcase
    endfunction

    function automatic issue_pkt_t make_op(logic rd_en, logic wr_en, logic [2:0] f3,
                                           logic use_alu, word_t addr, word_t data);
        issue_pkt_t op;
        op = '0;
        op.instr = lcg_next();
        op.pc = use_alu ? 32'h40000000 + (lcg_next() & 32'hfc) : addr;
        op.rd = reg_idx_t'(lcg_next());
        op.mem_ctrl.mem_read = rd_en;
        op.mem_ctrl.mem_write = wr_en;
        op.mem_ctrl.load_funct3 = load_funct3_e'(f3);
        op.mem_ctrl.store_funct3 = store_funct3_e'(f3);
        op.mem_ctrl.addr_sel = use_alu ? alu_out : pc_out;
        op.alu_out = use_alu ? addr : lcg_next();
        op.store_data = data;
        return op;
    endfunction

    // expected record, and the store applied to the reference memory
    function automatic commit_pkt_t expect_commit(issue_pkt_t op);
        commit_pkt_t e;
        word_t       addr;
        e = '0;
        addr = (op.mem_ctrl.addr_sel == alu_out) ? op.alu_out : op.pc;
        e.order = next_order;
        e.instr = op.instr;
        e.pc = op.pc;
        e.rd = op.rd;
        e.mem_wdata = op.store_data;
        e.mem_addr = addr;
        if ((op.mem_ctrl.mem_read || op.mem_ctrl.mem_write) && op.mem_ctrl.load_funct3 != lw) begin
            e.mem_addr = {addr[31:2], 2'b00};
        end
        if (op.mem_ctrl.mem_read) begin
            e.rmask = lane_mask(op.mem_ctrl.load_funct3, addr[1:0]);
            e.mem_rdata = ref_mem[addr[7:2]];
        end else if (op.mem_ctrl.mem_write) begin
            e.wmask = lane_mask(op.mem_ctrl.store_funct3, addr[1:0]);
            for (int b = 0; b < 4; b++) begin
                if (e.wmask[b]) ref_mem[addr[7:2]][b*8 +: 8] = op.store_data[b*8 +: 8];
            end
        end
        return e;
    endfunction

    // request the memory port should carry for this op
    function automatic dmem_req_t expect_request(issue_pkt_t op, commit_pkt_t rec);
        dmem_req_t r;
        r = '0;
        r.addr = rec.mem_addr;
        r.wdata = op.store_data;
        r.byte_en = rec.rmask | rec.wmask;  // loads use rmask, stores wmask
        r.read = op.mem_ctrl.mem_read;
        r.write = op.mem_ctrl.mem_write;
        return r;
    endfunction

    task automatic abort_run(string what);
        $display("timeout while %s at %0t", what, $time);
        $display("SOME TESTS FAILED");
        $finish;
    endtask

    task automatic send_op(issue_pkt_t op);
        int          cnt;
        commit_pkt_t rec;
        cnt = 0;
        op_i = op;
        op_valid_i = 1'b1;
        do begin
            @(posedge clk);
            cnt++;
            if (cnt > WAIT_LIMIT) abort_run("waiting for op_ready_o");
        end while (!op_ready_o);
        rec = expect_commit(op);
        exp_q.push_back(rec);
        next_order++;
        if (op.mem_ctrl.mem_read || op.mem_ctrl.mem_write) begin
            mem_ops++;
            req_exp_q.push_back(expect_request(op, rec));
        end
        #1 op_valid_i = 1'b0;
    endtask

    task automatic drain();
        int cnt;
        cnt = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            cnt++;
            if (cnt > WAIT_LIMIT) abort_run("draining commit records");
        end
        #1;  // next drive lands after the edge
        if (req_count != mem_ops) begin
            $display("Fail at %0t: %0d requests for %0d memory ops", $time, req_count, mem_ops);
            errors++;
        end
    endtask

    // data memory: random ready, random latency, one response per request
    initial begin : mem_server
        dmem_req_t req;
        dmem_req_t want;
        int        delay;
        forever begin
            @(posedge clk);
            if (!rst && dmem_req_valid_o && dmem_req_ready_i) begin
                req = dmem_req_o;
                req_count++;
                if (req_exp_q.size() == 0) begin
                    $display("Fail at %0t: request with no memory op pending", $time);
                    errors++;
                end else begin
                    want = req_exp_q.pop_front();
                    if (req !== want) begin
                        $display("Fail at %0t: request got %h expected %h", $time, req, want);
                        errors++;
                    end
                end
                delay = int'(lcg_next() % 4);
                #1 dmem_req_ready_i = 1'b0;
                repeat (delay) @(posedge clk);
                if (delay > 0) #1;
                dmem_resp_valid_i = 1'b1;
                dmem_rdata_i = req.read ? mem[req.addr[7:2]] : lcg_next();  // junk for stores
                if (req.write) begin
                    for (int b = 0; b < 4; b++) begin
                        if (req.byte_en[b]) mem[req.addr[7:2]][b*8 +: 8] = req.wdata[b*8 +: 8];
                    end
                end
                @(posedge clk);
                #1 dmem_resp_valid_i = 1'b0;
            end
            #1 dmem_req_ready_i = stall_en ? (lcg_next() % 3 != 0) : 1'b1;
        end
    end

    // retirement side compares each record with the scoreboard
    initial begin : commit_monitor
        commit_pkt_t exp;
        forever begin
            @(posedge clk);
            if (!rst && commit_valid_o && commit_ready_i) begin
                if (exp_q.size() == 0) begin
                    $display("Fail at %0t: unexpected commit, order %0d", $time, commit_o.order);
                    errors++;
                end else begin
                    exp = exp_q.pop_front();
                    if (commit_o !== exp) begin
                        $display("Fail at %0t: commit got %h expected %h", $time, commit_o, exp);
                        errors++;
                    end
                end
            end
            #1 commit_ready_i = stall_en ? (lcg_next() % 3 != 0) : 1'b1;
        end
    end

    task automatic check_reset();
        if (commit_valid_o !== 1'b0 || dmem_req_valid_o !== 1'b0 || op_ready_o !== 1'b1) begin
            $display("Fail at %0t: outputs after reset", $time);
            errors++;
        end
    endtask

    task automatic test_alu_ops();
        for (int i = 0; i < 5; i++) begin
            send_op(make_op(1'b0, 1'b0, 3'b000, 1'b1, lcg_next(), lcg_next()));
        end
        drain();
    endtask

    task automatic test_stores();
        for (int f = 0; f < 3; f++) begin
            for (int off = 0; off < 4; off++) begin
                send_op(make_op(1'b0, 1'b1, 3'(f), 1'b1, 32'h40 + 32'(f * 16 + off), lcg_next()));
            end
        end
        drain();
    endtask

    task automatic test_loads();
        logic [2:0] f3s [5] = '{3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
        for (int f = 0; f < 5; f++) begin
            for (int off = 0; off < 4; off++) begin
                send_op(make_op(1'b1, 1'b0, f3s[f], 1'b1, 32'h40 + 32'(off * 4 + off), '0));
                send_op(make_op(1'b1, 1'b0, f3s[f], 1'b0, 32'h40000080 + 32'(off), '0));
            end
        end
        drain();
    endtask

    task automatic send_random_op();
        logic [31:0] r;
        logic [2:0]  f3;
        r = lcg_next();
        f3 = (r[1:0] == 2'b11) ? 3'b100 : {1'b0, r[1:0]};
        case (r[4:3])
            2'b00:   send_op(make_op(1'b0, 1'b0, 3'b000, 1'b1, lcg_next(), lcg_next()));
            2'b01:   send_op(make_op(1'b1, 1'b0, f3, r[5], {24'd0, r[15:8]}, '0));
            default: send_op(make_op(1'b0, 1'b1, {1'b0, f3[1:0]}, 1'b1, {24'd0, r[15:8]},
                                     lcg_next()));
        endcase
    endtask

    task automatic test_stalls();
        stall_en = 1'b1;
        for (int i = 0; i < 40; i++) send_random_op();
        drain();
        stall_en = 1'b0;
    endtask

    task automatic test_mixed();
        for (int i = 0; i < 6; i++) begin
            send_op(make_op(1'b0, 1'b1, 3'b000, 1'b1, 32'h20 + 32'(i), lcg_next()));
            send_op(make_op(1'b1, 1'b0, 3'b010, 1'b1, 32'h20 + 32'(i & 4), '0));
            send_op(make_op(1'b1, 1'b0, 3'b100, 1'b1, 32'h20 + 32'(i), '0));
        end
        drain();
    endtask

    initial begin
        for (int i = 0; i < 64; i++) begin
            mem[i] = (32'(i) * 32'h01030507) ^ 32'ha5c30000;  // every word distinct
            ref_mem[i] = mem[i];
        end
        rst = 1'b1;
        op_i = '0;
        op_valid_i = 1'b0;
        dmem_req_ready_i = 1'b1;
        dmem_resp_valid_i = 1'b0;
        dmem_rdata_i = '0;
        commit_ready_i = 1'b1;
        repeat (16) @(posedge clk);
        #1 rst = 1'b0;
        check_reset();
        test_alu_ops();
        test_stores();
        test_loads();
        test_stalls();
        test_mixed();
        repeat (5) @(posedge clk);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+include
rtl/rv_pipe_pkg.sv
rtl/issue_reg.sv
rtl/byte_lane_gen.sv
rtl/exe_mem_reg.sv
rtl/mem_wb_reg.sv
rtl/rv_pipe_top.sv
tb/rv_pipe_assert.sv
tb/tb_top.sv

// File: Makefile
# Verilator build for the pipeline back end testbench

TOP             ?= tb_top
SIM_DIR         ?= obj_dir
FILE_LIST       ?= tb.f
PASS_TEXT       ?= ALL TESTS PASSED
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(SIM_DIR) -f $(FILE_LIST)

run: compile
	@out="$$(./$(SIM_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(SIM_DIR)
